// ==== files.f ====
+incdir+verification
hdl/mem_pkg.sv
hdl/mem_wait_timer.sv
hdl/store_align.sv
hdl/load_align.sv
hdl/apb_data_ram.sv
hdl/mem_access_fsm.sv
hdl/mem_stage_top.sv
verification/mem_stage_tb.sv

// ==== Makefile ====
TOP = mem_stage_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module mem_stage_top -f files.f

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/mem_stage_tb_tasks.svh ====
// waits until the stage can take a request
task automatic wait_pause_release();
    int n;
    n = 0;
    @(negedge clk);
    while (pause_mem_o && n < PAUSE_TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (pause_mem_o) begin
        $display("%s: pause_mem_o stayed high for %0d cycles", test_name, PAUSE_TIMEOUT);
        errors++;
    end
endtask

// accepted on the second rising edge
task automatic send_request(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] alu,
                            input logic [4:0] wa);
    wait_pause_release();
    @(posedge clk);
    valid_i <= 1'b1;
    op_i <= op;
    mem_addr_i <= addr;
    store_data_i <= data;
    alu_result_i <= alu;
    reg_write_en_i <= 1'b1;
    reg_write_addr_i <= wa;
    @(posedge clk);
    valid_i <= 1'b0;
endtask

// counts cycles from the accepting edge
task automatic wait_writeback(output int cycles, output bit saw_pause, output bit timed_out);
    mem_pkg::fsm_state_e st;
    cycles = 0;
    saw_pause = 1'b0;
    timed_out = 1'b0;
    do begin
        @(negedge clk);
        cycles++;
        if (pause_mem_o) begin
            saw_pause = 1'b1;
        end
    end while (!wb_valid_o && cycles < WB_TIMEOUT);
    if (!wb_valid_o) begin
        st = dut_i.fsm_i.state_q;
        $display("%s: no writeback after %0d cycles, fsm in %s", test_name, WB_TIMEOUT, st.name());
        errors++;
        timed_out = 1'b1;
    end
endtask

// ==== verification/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int WB_TIMEOUT = 64;
    localparam int PAUSE_TIMEOUT = 64;

    logic                              clk;
    logic                              rst_i;
    logic                              valid_i;
    mem_pkg::mem_op_e                  op_i;
    logic [mem_pkg::ADDR_W-1:0]        mem_addr_i;
    logic [mem_pkg::DATA_W-1:0]        store_data_i;
    logic [mem_pkg::DATA_W-1:0]        alu_result_i;
    logic                              reg_write_en_i;
    logic [mem_pkg::REG_ADDR_W-1:0]    reg_write_addr_i;
    logic                              pause_mem_o;
    logic                              wb_valid_o;
    logic                              wb_reg_write_en_o;
    logic [mem_pkg::REG_ADDR_W-1:0]    wb_reg_write_addr_o;
    logic [mem_pkg::DATA_W-1:0]        wb_reg_write_data_o;
    logic                              wb_is_exception_o;
    mem_pkg::exc_cause_e               wb_exception_cause_o;

    // byte image of ram region 0
    logic [7:0] ref_mem [4096];
    int seed;
    int errors;
    int checks;
    int tests;
    int test_err_base;
    int last_cycles;
    string test_name;

    mem_stage_top dut_i (
        .clk                  (clk),
        .rst_i                (rst_i),
        .valid_i              (valid_i),
        .op_i                 (op_i),
        .mem_addr_i           (mem_addr_i),
        .store_data_i         (store_data_i),
        .alu_result_i         (alu_result_i),
        .reg_write_en_i       (reg_write_en_i),
        .reg_write_addr_i     (reg_write_addr_i),
        .pause_mem_o          (pause_mem_o),
        .wb_valid_o           (wb_valid_o),
        .wb_reg_write_en_o    (wb_reg_write_en_o),
        .wb_reg_write_addr_o  (wb_reg_write_addr_o),
        .wb_reg_write_data_o  (wb_reg_write_data_o),
        .wb_is_exception_o    (wb_is_exception_o),
        .wb_exception_cause_o (wb_exception_cause_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    wb_pause_excl: assert property (@(posedge clk) disable iff (rst_i)
                                    !(wb_valid_o && pause_mem_o))
        else begin
            $display("wb_valid_o and pause_mem_o were high together at %0t", $time);
            errors++;
        end

    no_req_in_pause: assert property (@(posedge clk) disable iff (rst_i)
                                      !(valid_i && pause_mem_o))
        else begin
            $display("valid_i was driven while pause_mem_o was high at %0t", $time);
            errors++;
        end

    `include "mem_stage_tb_tasks.svh"

    function automatic logic [31:0] model_load(input mem_pkg::mem_op_e op,
                                               input logic [31:0] addr);
        logic [7:0] b;
        logic [15:0] h;
        logic [31:0] w;
        b = ref_mem[addr[11:0]];
        h = {ref_mem[{addr[11:1], 1'b1}], ref_mem[{addr[11:1], 1'b0}]};
        w = {ref_mem[{addr[11:2], 2'd3}], ref_mem[{addr[11:2], 2'd2}],
             ref_mem[{addr[11:2], 2'd1}], ref_mem[{addr[11:2], 2'd0}]};
        case (op)
            mem_pkg::OP_LD_B:  return {{24{b[7]}}, b};
            mem_pkg::OP_LD_BU: return {24'b0, b};
            mem_pkg::OP_LD_H:  return {{16{h[15]}}, h};
            mem_pkg::OP_LD_HU: return {16'b0, h};
            default:           return w;
        endcase
    endfunction

    function automatic void model_store(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                                        input logic [31:0] data);
        case (op)
            mem_pkg::OP_ST_B: begin
                ref_mem[addr[11:0]] = data[7:0];
            end
            mem_pkg::OP_ST_H: begin
                ref_mem[{addr[11:1], 1'b0}] = data[7:0];
                ref_mem[{addr[11:1], 1'b1}] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{addr[11:2], i[1:0]}] = data[8*i +: 8];
                end
            end
        endcase
    endfunction

    task automatic check_wb(input logic exp_we, input logic [31:0] exp_data,
                            input logic [4:0] exp_wa, input mem_pkg::exc_cause_e exp_cause);
        checks++;
        assert (wb_exception_cause_o == exp_cause) else begin
            $display("FAIL %s: cause expected %s actual %s", test_name, exp_cause.name(),
                     wb_exception_cause_o.name());
            errors++;
        end
        assert (wb_is_exception_o == (exp_cause != mem_pkg::EXC_NONE)) else begin
            $display("FAIL %s: is_exception expected %b actual %b", test_name,
                     exp_cause != mem_pkg::EXC_NONE, wb_is_exception_o);
            errors++;
        end
        assert (wb_reg_write_en_o == exp_we) else begin
            $display("FAIL %s: reg_write_en expected %b actual %b", test_name, exp_we,
                     wb_reg_write_en_o);
            errors++;
        end
        if (exp_we) begin
            assert (wb_reg_write_data_o == exp_data && wb_reg_write_addr_o == exp_wa) else begin
                $display("FAIL %s: r%0d data expected %08h actual r%0d %08h", test_name, exp_wa,
                         exp_data, wb_reg_write_addr_o, wb_reg_write_data_o);
                errors++;
            end
        end
    endtask

    task automatic mem_access(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] data, input logic exp_we,
                              input logic [31:0] exp_data, input mem_pkg::exc_cause_e exp_cause);
        bit saw_pause;
        bit timed_out;
        logic [4:0] wa;
        wa = 5'($random(seed));
        send_request(op, addr, data, $random(seed), wa);
        wait_writeback(last_cycles, saw_pause, timed_out);
        if (!timed_out) begin
            check_wb(exp_we, exp_data, wa, exp_cause);
            // only a bus transfer pauses execute
            assert (saw_pause == (exp_cause != mem_pkg::EXC_ALE)) else begin
                $display("%s: pause_mem_o wrong around %s at %08h", test_name, op.name(), addr);
                errors++;
            end
        end
    endtask

    task automatic do_store(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] data);
        mem_access(op, addr, data, 1'b0, '0, mem_pkg::EXC_NONE);
        model_store(op, addr, data);
    endtask

    task automatic check_load(input mem_pkg::mem_op_e op, input logic [31:0] addr);
        mem_access(op, addr, $random(seed), 1'b1, model_load(op, addr), mem_pkg::EXC_NONE);
    endtask

    task automatic expect_fault(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                                input mem_pkg::exc_cause_e cause);
        mem_access(op, addr, $random(seed), 1'b0, '0, cause);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_base = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %0d errors", test_name, errors - test_err_base);
    endtask

    initial begin
        logic [31:0] alu_vals [8];
        logic [4:0] wa_vals [8];
        logic we_vals [8];
        logic [31:0] addrs [8];
        logic [31:0] data;
        logic [31:0] base;
        seed = 63;
        errors = 0;
        checks = 0;
        tests = 0;
        rst_i = 1'b1;
        valid_i = 1'b0;
        op_i = mem_pkg::OP_NONE;
        mem_addr_i = '0;
        store_data_i = '0;
        alu_result_i = '0;
        reg_write_en_i = 1'b0;
        reg_write_addr_i = '0;
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;

        start_test("reset");
        repeat (3) begin
            @(negedge clk);
            checks++;
            assert (!wb_valid_o && !pause_mem_o) else begin
                $display("FAIL reset: wb_valid/pause expected 00 actual %b%b", wb_valid_o,
                         pause_mem_o);
                errors++;
            end
        end
        end_test();

        // one op per cycle with its writeback right after the accepting edge
        start_test("nonmem_stream");
        for (int i = 0; i <= 8; i++) begin
            @(posedge clk);
            if (i < 8) begin
                alu_vals[i] = $random(seed);
                wa_vals[i] = 5'($random(seed));
                // op 3 carries no register write
                we_vals[i] = (i != 3);
                valid_i <= 1'b1;
                op_i <= mem_pkg::OP_NONE;
                alu_result_i <= alu_vals[i];
                reg_write_en_i <= we_vals[i];
                reg_write_addr_i <= wa_vals[i];
            end else begin
                valid_i <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                assert (wb_valid_o && !pause_mem_o) else begin
                    $display("FAIL nonmem_stream: wb_valid/pause expected 10 actual %b%b",
                             wb_valid_o, pause_mem_o);
                    errors++;
                end
                check_wb(we_vals[i-1], alu_vals[i-1], wa_vals[i-1], mem_pkg::EXC_NONE);
            end
        end
        end_test();

        start_test("word_store_load");
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed) & 32'h0000_0ffc;
            do_store(mem_pkg::OP_ST_W, addrs[i], $random(seed));
        end
        for (int i = 0; i < 8; i++) begin
            check_load(mem_pkg::OP_LD_W, addrs[i]);
        end
        end_test();

        start_test("subword");
        base = $random(seed) & 32'h0000_0ff0;
        do_store(mem_pkg::OP_ST_W, base, $random(seed));
        do_store(mem_pkg::OP_ST_W, base + 32'd4, $random(seed));
        for (int off = 0; off < 4; off++) begin
            data = $random(seed);
            data[7] = (off % 2 == 0);
            do_store(mem_pkg::OP_ST_B, base + 32'(off), data);
            check_load(mem_pkg::OP_LD_W, base);
        end
        for (int off = 0; off < 4; off++) begin
            check_load(mem_pkg::OP_LD_B, base + 32'(off));
            check_load(mem_pkg::OP_LD_BU, base + 32'(off));
        end
        for (int off = 2; off >= 0; off -= 2) begin
            data = $random(seed);
            data[15] = (off == 2);
            do_store(mem_pkg::OP_ST_H, base + 32'd4 + 32'(off), data);
            check_load(mem_pkg::OP_LD_W, base + 32'd4);
            check_load(mem_pkg::OP_LD_H, base + 32'd4 + 32'(off));
            check_load(mem_pkg::OP_LD_HU, base + 32'd4 + 32'(off));
        end
        end_test();

        start_test("misaligned");
        base = $random(seed) & 32'h0000_0ffc;
        expect_fault(mem_pkg::OP_LD_H, base + 32'd1, mem_pkg::EXC_ALE);
        expect_fault(mem_pkg::OP_LD_W, base + 32'd2, mem_pkg::EXC_ALE);
        expect_fault(mem_pkg::OP_ST_H, base + 32'd3, mem_pkg::EXC_ALE);
        expect_fault(mem_pkg::OP_ST_W, base + 32'd1, mem_pkg::EXC_ALE);
        assert (last_cycles == 1) else begin
            $display("FAIL misaligned: latency expected 1 actual %0d", last_cycles);
            errors++;
        end
        check_load(mem_pkg::OP_LD_W, base);
        end_test();

        start_test("bus_error");
        expect_fault(mem_pkg::OP_LD_W, 32'h0000_1000 | ($random(seed) & 32'h0ffc),
                     mem_pkg::EXC_BUS_ERR);
        expect_fault(mem_pkg::OP_ST_W, 32'h0000_1004, mem_pkg::EXC_BUS_ERR);
        expect_fault(mem_pkg::OP_LD_B, 32'h0000_2003, mem_pkg::EXC_BUS_TIMEOUT);
        assert (last_cycles >= mem_pkg::BUS_TIMEOUT_CYCLES) else begin
            $display("FAIL bus_error: timeout latency expected >= %0d actual %0d",
                     mem_pkg::BUS_TIMEOUT_CYCLES, last_cycles);
            errors++;
        end
        expect_fault(mem_pkg::OP_ST_W, 32'h0000_2008, mem_pkg::EXC_BUS_TIMEOUT);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                              clk,
    input  logic                              rst_i,

    // from execute
    input  logic                              valid_i,
    input  mem_pkg::mem_op_e                  op_i,
    input  logic [mem_pkg::ADDR_W-1:0]        mem_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]        store_data_i,
    input  logic [mem_pkg::DATA_W-1:0]        alu_result_i,
    input  logic                              reg_write_en_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0]    reg_write_addr_i,

    // to ctrl
    output logic                              pause_mem_o,

    // to writeback
    output logic                              wb_valid_o,
    output logic                              wb_reg_write_en_o,
    output logic [mem_pkg::REG_ADDR_W-1:0]    wb_reg_write_addr_o,
    output logic [mem_pkg::DATA_W-1:0]        wb_reg_write_data_o,
    output logic                              wb_is_exception_o,
    output mem_pkg::exc_cause_e               wb_exception_cause_o
);

    mem_pkg::mem_op_e               req_op;
    logic [mem_pkg::ADDR_W-1:0]     req_addr;
    logic [mem_pkg::DATA_W-1:0]     req_store_data;
    logic [mem_pkg::DATA_W-1:0]     load_data;

    // apb
    logic [mem_pkg::ADDR_W-1:0]     paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [mem_pkg::DATA_W-1:0]     pwdata;
    logic [mem_pkg::STRB_W-1:0]     pstrb;
    logic [mem_pkg::DATA_W-1:0]     prdata;
    logic                           pready;
    logic                           pslverr;

    logic timer_clear;
    logic timer_run;
    logic timer_expired;

    mem_access_fsm fsm_i (
        .clk                  (clk),
        .rst_i                (rst_i),
        .valid_i              (valid_i),
        .op_i                 (op_i),
        .mem_addr_i           (mem_addr_i),
        .store_data_i         (store_data_i),
        .alu_result_i         (alu_result_i),
        .reg_write_en_i       (reg_write_en_i),
        .reg_write_addr_i     (reg_write_addr_i),
        .req_op_o             (req_op),
        .req_addr_o           (req_addr),
        .req_store_data_o     (req_store_data),
        .paddr_o              (paddr),
        .psel_o               (psel),
        .penable_o            (penable),
        .pwrite_o             (pwrite),
        .pready_i             (pready),
        .pslverr_i            (pslverr),
        .load_data_i          (load_data),
        .timer_clear_o        (timer_clear),
        .timer_run_o          (timer_run),
        .timer_expired_i      (timer_expired),
        .pause_mem_o          (pause_mem_o),
        .wb_valid_o           (wb_valid_o),
        .wb_reg_write_en_o    (wb_reg_write_en_o),
        .wb_reg_write_addr_o  (wb_reg_write_addr_o),
        .wb_reg_write_data_o  (wb_reg_write_data_o),
        .wb_is_exception_o    (wb_is_exception_o),
        .wb_exception_cause_o (wb_exception_cause_o)
    );

    mem_wait_timer timer_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .clear_i   (timer_clear),
        .run_i     (timer_run),
        .expired_o (timer_expired)
    );

    store_align store_align_i (
        .op_i         (req_op),
        .addr_lo_i    (req_addr[1:0]),
        .store_data_i (req_store_data),
        .pwdata_o     (pwdata),
        .pstrb_o      (pstrb)
    );

    load_align load_align_i (
        .op_i        (req_op),
        .addr_lo_i   (req_addr[1:0]),
        .rdata_i     (prdata),
        .load_data_o (load_data)
    );

    apb_data_ram ram_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .paddr_i   (paddr),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .pstrb_i   (pstrb),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

endmodule

// ==== hdl/mem_access_fsm.sv ====
`timescale 1ns/1ps

module mem_access_fsm (
    input  logic                              clk,
    input  logic                              rst_i,

    // from execute
    input  logic                              valid_i,
    input  mem_pkg::mem_op_e                  op_i,
    input  logic [mem_pkg::ADDR_W-1:0]        mem_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]        store_data_i,
    input  logic [mem_pkg::DATA_W-1:0]        alu_result_i,
    input  logic                              reg_write_en_i,
    input  logic [mem_pkg::REG_ADDR_W-1:0]    reg_write_addr_i,

    // latched request for the aligners
    output mem_pkg::mem_op_e                  req_op_o,
    output logic [mem_pkg::ADDR_W-1:0]        req_addr_o,
    output logic [mem_pkg::DATA_W-1:0]        req_store_data_o,

    // apb master
    output logic [mem_pkg::ADDR_W-1:0]        paddr_o,
    output logic                              psel_o,
    output logic                              penable_o,
    output logic                              pwrite_o,
    input  logic                              pready_i,
    input  logic                              pslverr_i,
    input  logic [mem_pkg::DATA_W-1:0]        load_data_i,

    // access timer
    output logic                              timer_clear_o,
    output logic                              timer_run_o,
    input  logic                              timer_expired_i,

    // to ctrl and writeback
    output logic                              pause_mem_o,
    output logic                              wb_valid_o,
    output logic                              wb_reg_write_en_o,
    output logic [mem_pkg::REG_ADDR_W-1:0]    wb_reg_write_addr_o,
    output logic [mem_pkg::DATA_W-1:0]        wb_reg_write_data_o,
    output logic                              wb_is_exception_o,
    output mem_pkg::exc_cause_e               wb_exception_cause_o
);

    mem_pkg::fsm_state_e                state_q;
    mem_pkg::mem_op_e                   req_op_q;
    logic [mem_pkg::ADDR_W-1:0]         req_addr_q;
    logic [mem_pkg::DATA_W-1:0]         req_store_data_q;

    logic accept;
    logic in_is_mem;
    logic in_misaligned;
    logic req_is_load;
    logic req_is_store;

    assign accept = valid_i && (state_q == mem_pkg::ST_IDLE);
    assign in_is_mem = (op_i != mem_pkg::OP_NONE);

    // halfwords need bit 0 clear, words need bits 1:0 clear
    always_comb begin
        case (op_i)
            mem_pkg::OP_LD_H, mem_pkg::OP_LD_HU, mem_pkg::OP_ST_H:
                in_misaligned = mem_addr_i[0];
            mem_pkg::OP_LD_W, mem_pkg::OP_ST_W:
                in_misaligned = |mem_addr_i[1:0];
            default:
                in_misaligned = 1'b0;
        endcase
    end

    assign req_is_load = req_op_q inside {mem_pkg::OP_LD_B, mem_pkg::OP_LD_BU, mem_pkg::OP_LD_H,
                                          mem_pkg::OP_LD_HU, mem_pkg::OP_LD_W};
    assign req_is_store = req_op_q inside {mem_pkg::OP_ST_B, mem_pkg::OP_ST_H, mem_pkg::OP_ST_W};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= mem_pkg::ST_IDLE;
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= 1'b0;
            case (state_q)
                mem_pkg::ST_IDLE: begin
                    if (accept && in_is_mem && !in_misaligned) begin
                        state_q <= mem_pkg::ST_SETUP;
                    end else if (accept) begin
                        wb_valid_o <= 1'b1;
                    end
                end
                mem_pkg::ST_SETUP: begin
                    state_q <= mem_pkg::ST_ACCESS;
                end
                mem_pkg::ST_ACCESS: begin
                    if (pready_i || timer_expired_i) begin
                        state_q <= mem_pkg::ST_IDLE;
                        wb_valid_o <= 1'b1;
                    end
                end
                default: begin
                    state_q <= mem_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // request and writeback payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_op_q <= op_i;
            req_addr_q <= mem_addr_i;
            req_store_data_q <= store_data_i;
            wb_reg_write_addr_o <= reg_write_addr_i;
            wb_reg_write_data_o <= alu_result_i;
            if (in_misaligned) begin
                wb_reg_write_en_o <= 1'b0;
                wb_is_exception_o <= 1'b1;
                wb_exception_cause_o <= mem_pkg::EXC_ALE;
            end else begin
                wb_reg_write_en_o <= reg_write_en_i;
                wb_is_exception_o <= 1'b0;
                wb_exception_cause_o <= mem_pkg::EXC_NONE;
            end
        end else if (state_q == mem_pkg::ST_ACCESS && (pready_i || timer_expired_i)) begin
            wb_reg_write_data_o <= req_is_load ? load_data_i : '0;
            if (!pready_i) begin
                wb_reg_write_en_o <= 1'b0;
                wb_is_exception_o <= 1'b1;
                wb_exception_cause_o <= mem_pkg::EXC_BUS_TIMEOUT;
            end else if (pslverr_i) begin
                wb_reg_write_en_o <= 1'b0;
                wb_is_exception_o <= 1'b1;
                wb_exception_cause_o <= mem_pkg::EXC_BUS_ERR;
            end else begin
                wb_reg_write_en_o <= req_is_load;
                wb_is_exception_o <= 1'b0;
                wb_exception_cause_o <= mem_pkg::EXC_NONE;
            end
        end
    end

    assign req_op_o = req_op_q;
    assign req_addr_o = req_addr_q;
    assign req_store_data_o = req_store_data_q;

    assign paddr_o = req_addr_q;
    assign psel_o = (state_q != mem_pkg::ST_IDLE);
    assign penable_o = (state_q == mem_pkg::ST_ACCESS);
    assign pwrite_o = req_is_store;

    assign timer_clear_o = (state_q == mem_pkg::ST_SETUP);
    assign timer_run_o = (state_q == mem_pkg::ST_ACCESS);

    assign pause_mem_o = (state_q != mem_pkg::ST_IDLE);

endmodule

// ==== hdl/apb_data_ram.sv ====
`timescale 1ns/1ps

module apb_data_ram (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [mem_pkg::ADDR_W-1:0]     paddr_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [mem_pkg::DATA_W-1:0]     pwdata_i,
    input  logic [mem_pkg::STRB_W-1:0]     pstrb_i,
    output logic [mem_pkg::DATA_W-1:0]     prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o
);

    logic [mem_pkg::DATA_W-1:0]     mem [mem_pkg::RAM_WORDS];
    logic [1:0]                     region;
    logic [mem_pkg::RAM_IDX_W-1:0]  word_idx;
    logic [mem_pkg::WAIT_CNT_W-1:0] wait_cnt_q;
    logic                           sel_ram;
    logic                           sel_err;
    logic                           ram_ready;

    assign region = paddr_i[13:12];
    assign word_idx = paddr_i[mem_pkg::RAM_IDX_W+1:2];

    // regions 2 and 3 have no slave and never answer
    assign sel_ram = psel_i && (region == mem_pkg::REGION_RAM);
    assign sel_err = psel_i && (region == mem_pkg::REGION_ERR);

    assign ram_ready = sel_ram && penable_i && (wait_cnt_q == mem_pkg::RAM_WAIT_CNT);

    // wait states of the ram region
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wait_cnt_q <= '0;
        end else if (sel_ram && penable_i && !ram_ready) begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
        end else begin
            wait_cnt_q <= '0;
        end
    end

    initial begin
        for (int i = 0; i < mem_pkg::RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_ready && pwrite_i) begin
            for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                if (pstrb_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= pwdata_i[b*8 +: 8];
                end
            end
        end
    end

    assign prdata_o = ram_ready ? mem[word_idx] : '0;

    // error region completes in its first access cycle
    assign pready_o = ram_ready || (sel_err && penable_i);
    assign pslverr_o = sel_err && penable_i;

endmodule

// ==== hdl/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  mem_pkg::mem_op_e               op_i,
    input  logic [1:0]                     addr_lo_i,
    input  logic [mem_pkg::DATA_W-1:0]     rdata_i,
    output logic [mem_pkg::DATA_W-1:0]     load_data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lane select from the low address bits
    always_comb begin
        case (addr_lo_i)
            2'b00:   byte_lane = rdata_i[7:0];
            2'b01:   byte_lane = rdata_i[15:8];
            2'b10:   byte_lane = rdata_i[23:16];
            default: byte_lane = rdata_i[31:24];
        endcase
    end

    assign half_lane = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (op_i)
            mem_pkg::OP_LD_B: begin
                load_data_o = {{24{byte_lane[7]}}, byte_lane};
            end
            mem_pkg::OP_LD_BU: begin
                load_data_o = {24'b0, byte_lane};
            end
            mem_pkg::OP_LD_H: begin
                load_data_o = {{16{half_lane[15]}}, half_lane};
            end
            mem_pkg::OP_LD_HU: begin
                load_data_o = {16'b0, half_lane};
            end
            mem_pkg::OP_LD_W: begin
                load_data_o = rdata_i;
            end
            default: begin
                load_data_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/store_align.sv ====
`timescale 1ns/1ps

module store_align (
    input  mem_pkg::mem_op_e               op_i,
    input  logic [1:0]                     addr_lo_i,
    input  logic [mem_pkg::DATA_W-1:0]     store_data_i,
    output logic [mem_pkg::DATA_W-1:0]     pwdata_o,
    output logic [mem_pkg::STRB_W-1:0]     pstrb_o
);

    always_comb begin
        case (op_i)
            mem_pkg::OP_ST_B: begin
                // byte on every lane, strobe picks one
                pwdata_o = {4{store_data_i[7:0]}};
                pstrb_o = 4'b0001 << addr_lo_i;
            end
            mem_pkg::OP_ST_H: begin
                pwdata_o = {2{store_data_i[15:0]}};
                pstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            mem_pkg::OP_ST_W: begin
                pwdata_o = store_data_i;
                pstrb_o = 4'b1111;
            end
            default: begin
                // reads carry no strobes
                pwdata_o = store_data_i;
                pstrb_o = 4'b0000;
            end
        endcase
    end

endmodule

// ==== hdl/mem_wait_timer.sv ====
`timescale 1ns/1ps

module mem_wait_timer (
    input  logic clk,
    input  logic rst_i,
    input  logic clear_i,
    input  logic run_i,
    output logic expired_o
);

    logic [mem_pkg::TIMER_W-1:0] cnt_q;

    // counts access cycles, holds at the limit
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (run_i && !expired_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign expired_o = (cnt_q == mem_pkg::TIMEOUT_CNT);

endmodule

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // bus and data widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int REG_ADDR_W = 5;

    // data ram geometry and timing
    localparam int RAM_WORDS = 1024;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);
    localparam int RAM_WAIT_CYCLES = 2;
    localparam int WAIT_CNT_W = $clog2(RAM_WAIT_CYCLES + 1);
    localparam logic [WAIT_CNT_W-1:0] RAM_WAIT_CNT = RAM_WAIT_CYCLES[WAIT_CNT_W-1:0];

    // access cycles before a missing slave is reported
    localparam int BUS_TIMEOUT_CYCLES = 16;
    localparam int TIMER_W = $clog2(BUS_TIMEOUT_CYCLES + 1);
    localparam logic [TIMER_W-1:0] TIMEOUT_CNT = BUS_TIMEOUT_CYCLES[TIMER_W-1:0];

    // address map, selected by mem_addr[13:12]
    localparam logic [1:0] REGION_RAM = 2'd0;
    localparam logic [1:0] REGION_ERR = 2'd1;

    typedef enum logic [3:0] {
        OP_NONE  = 4'd0,
        OP_LD_B  = 4'd1,
        OP_LD_BU = 4'd2,
        OP_LD_H  = 4'd3,
        OP_LD_HU = 4'd4,
        OP_LD_W  = 4'd5,
        OP_ST_B  = 4'd6,
        OP_ST_H  = 4'd7,
        OP_ST_W  = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        EXC_NONE        = 2'd0,
        EXC_ALE         = 2'd1,
        EXC_BUS_ERR     = 2'd2,
        EXC_BUS_TIMEOUT = 2'd3
    } exc_cause_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SETUP  = 2'd1,
        ST_ACCESS = 2'd2
    } fsm_state_e;

endpackage
